//--- rtl/decode_pkg.sv
// Shared widths, encodings, control enums and bundles of the RV32I decode stage
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes
    localparam logic [6:0] OP_OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    // Selects SUB, SRA and SRAI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // funct3 of the arithmetic groups
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SR      = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // funct3 of branches, JALR, loads and stores
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;
    localparam logic [2:0] FUNCT3_JALR = 3'b000;
    localparam logic [2:0] FUNCT3_LB   = 3'b000;
    localparam logic [2:0] FUNCT3_LH   = 3'b001;
    localparam logic [2:0] FUNCT3_LW   = 3'b010;
    localparam logic [2:0] FUNCT3_LBU  = 3'b100;
    localparam logic [2:0] FUNCT3_LHU  = 3'b101;
    localparam logic [2:0] FUNCT3_SB   = 3'b000;
    localparam logic [2:0] FUNCT3_SH   = 3'b001;
    localparam logic [2:0] FUNCT3_SW   = 3'b010;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {OPSEL1_NONE, OPSEL1_RS1, OPSEL1_PC} opsel1_e;
    typedef enum logic [1:0] {OPSEL2_NONE, OPSEL2_RS2, OPSEL2_IMM, OPSEL2_FOUR} opsel2_e;
    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_IMM, WB_DMEM} wbsel_e;
    typedef enum logic {PC_PLUS4, PC_BRANCH} pcsel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_kind_e;

    // All five immediate formats, already extended to XLEN
    typedef struct packed {
        logic [XLEN-1:0] i;
        logic [XLEN-1:0] s;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] u;
        logic [XLEN-1:0] j;
    } imm_set_t;

    typedef struct packed {
        alu_op_e               alu_op;
        opsel1_e               opsel1;
        opsel2_e               opsel2;
        wbsel_e                wbsel;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rf_w_en;
        logic                  mem_w_en;
        logic                  load_flag;
        logic [XLEN-1:0]       imm;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        ctrl_t           ctrl;
        logic [XLEN-1:0] rs1_value;
        logic [XLEN-1:0] rs2_value;
    } id_ex_t;

endpackage

//--- rtl/imm_gen.sv
// Instruction field slicer and RV32I immediate generator
`timescale 1ns/1ps

module imm_gen import decode_pkg::*; (
    input  logic [XLEN-1:0]       inst_i,
    output imm_set_t              imm_o,
    output logic [REG_ADDR_W-1:0] rs1_idx_o,
    output logic [REG_ADDR_W-1:0] rs2_idx_o,
    output logic [REG_ADDR_W-1:0] rd_idx_o
);

    logic sign;

    assign sign = inst_i[31];

    // Register indices sit at the same place in every format
    assign rs1_idx_o = inst_i[19:15];
    assign rs2_idx_o = inst_i[24:20];
    assign rd_idx_o  = inst_i[11:7];

    // I and S share the top bits, S moves the low five down to rd's slot
    assign imm_o.i = {{(XLEN-12){sign}}, inst_i[31:20]};
    assign imm_o.s = {{(XLEN-12){sign}}, inst_i[31:25], inst_i[11:7]};

    // B format keeps bit 11 in inst[7], offset is always even
    assign imm_o.b = {{(XLEN-13){sign}},
                      inst_i[31],
                      inst_i[7],
                      inst_i[30:25],
                      inst_i[11:8],
                      1'b0};

    assign imm_o.u = {inst_i[31:12], 12'b0};

    // J format scatters bits 19:12, 11 and 10:1
    assign imm_o.j = {{(XLEN-21){sign}},
                      inst_i[31],
                      inst_i[19:12],
                      inst_i[20],
                      inst_i[30:21],
                      1'b0};

endmodule

//--- rtl/ctrl_decode.sv
// Control decoder mapping opcode and funct fields to the execute control bundle
`timescale 1ns/1ps

module ctrl_decode import decode_pkg::*; (
    input  logic [XLEN-1:0]       inst_i,
    input  imm_set_t              imm_i,
    input  logic [REG_ADDR_W-1:0] rs1_idx_i,
    input  logic [REG_ADDR_W-1:0] rs2_idx_i,
    input  logic [REG_ADDR_W-1:0] rd_idx_i,
    output ctrl_t                 ctrl_o,
    output br_kind_e              br_kind_o,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       is_shift;
    logic       op_ok;
    logic       op_imm_ok;
    alu_op_e    base_op;
    alu_op_e    imm_op;

    assign opcode   = inst_i[6:0];
    assign funct3   = inst_i[14:12];
    assign funct7   = inst_i[31:25];
    assign alt      = (funct7 == FUNCT7_ALT);
    assign is_shift = (funct3 == FUNCT3_SLL) || (funct3 == FUNCT3_SR);

    // Register-register form allows the alternate funct7 only on ADD/SUB and shifts right
    assign op_ok = (funct7 == '0) ||
                   (alt && (funct3 == FUNCT3_ADD_SUB || funct3 == FUNCT3_SR));
    // Immediate form checks funct7 on shifts only, SLLI has no alternate
    assign op_imm_ok = !is_shift || (funct7 == '0) || (alt && funct3 == FUNCT3_SR);

    always_comb begin
        case (funct3)
            FUNCT3_ADD_SUB: base_op = alt ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL:     base_op = ALU_SLL;
            FUNCT3_SLT:     base_op = ALU_SLT;
            FUNCT3_SLTU:    base_op = ALU_SLTU;
            FUNCT3_XOR:     base_op = ALU_XOR;
            FUNCT3_SR:      base_op = alt ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:      base_op = ALU_OR;
            FUNCT3_AND:     base_op = ALU_AND;
        endcase
    end

    // ADDI has no subtract form
    assign imm_op = (funct3 == FUNCT3_ADD_SUB) ? ALU_ADD : base_op;

    // Common shape of every instruction that writes an ALU result
    function automatic ctrl_t alu_ctrl(alu_op_e op, opsel2_e src2,
                                       logic [XLEN-1:0] imm,
                                       logic [REG_ADDR_W-1:0] rd);
        ctrl_t c;
        c          = '0;
        c.alu_op   = op;
        c.opsel1   = OPSEL1_RS1;
        c.opsel2   = src2;
        c.wbsel    = WB_ALU;
        c.rd_addr  = rd;
        c.rf_w_en  = 1'b1;
        c.imm      = imm;
        return c;
    endfunction

    always_comb begin
        ctrl_o     = '0;
        br_kind_o  = BR_NONE;
        rs1_addr_o = '0;
        rs2_addr_o = '0;
        case (opcode)
            OP_OP: if (op_ok) begin
                ctrl_o     = alu_ctrl(base_op, OPSEL2_RS2, '0, rd_idx_i);
                rs1_addr_o = rs1_idx_i;
                rs2_addr_o = rs2_idx_i;
            end
            OP_OP_IMM: if (op_imm_ok) begin
                // Shift amount comes straight from the shamt field
                ctrl_o     = alu_ctrl(imm_op, OPSEL2_IMM,
                                      is_shift ? XLEN'(inst_i[24:20]) : imm_i.i, rd_idx_i);
                rs1_addr_o = rs1_idx_i;
            end
            OP_LUI: begin
                ctrl_o.wbsel   = WB_IMM;
                ctrl_o.rd_addr = rd_idx_i;
                ctrl_o.rf_w_en = 1'b1;
                ctrl_o.imm     = imm_i.u;
            end
            OP_AUIPC: begin
                ctrl_o        = alu_ctrl(ALU_ADD, OPSEL2_IMM, imm_i.u, rd_idx_i);
                ctrl_o.opsel1 = OPSEL1_PC;
            end
            // Jumps link through PC + 4 in the ALU
            OP_JAL: begin
                ctrl_o        = alu_ctrl(ALU_ADD, OPSEL2_FOUR, imm_i.j, rd_idx_i);
                ctrl_o.opsel1 = OPSEL1_PC;
                br_kind_o     = BR_JAL;
            end
            OP_JALR: if (funct3 == FUNCT3_JALR) begin
                ctrl_o        = alu_ctrl(ALU_ADD, OPSEL2_FOUR, imm_i.i, rd_idx_i);
                ctrl_o.opsel1 = OPSEL1_PC;
                br_kind_o     = BR_JALR;
                rs1_addr_o    = rs1_idx_i;
            end
            OP_BRANCH: begin
                case (funct3)
                    FUNCT3_BEQ:  br_kind_o = BR_EQ;
                    FUNCT3_BNE:  br_kind_o = BR_NE;
                    FUNCT3_BLT:  br_kind_o = BR_LT;
                    FUNCT3_BGE:  br_kind_o = BR_GE;
                    FUNCT3_BLTU: br_kind_o = BR_LTU;
                    FUNCT3_BGEU: br_kind_o = BR_GEU;
                    default:     br_kind_o = BR_NONE;
                endcase
                if (br_kind_o != BR_NONE) begin
                    ctrl_o.imm = imm_i.b;
                    rs1_addr_o = rs1_idx_i;
                    rs2_addr_o = rs2_idx_i;
                end
            end
            OP_LOAD: if (funct3 inside {FUNCT3_LB, FUNCT3_LH, FUNCT3_LW,
                                        FUNCT3_LBU, FUNCT3_LHU}) begin
                ctrl_o           = alu_ctrl(ALU_ADD, OPSEL2_IMM, imm_i.i, rd_idx_i);
                ctrl_o.wbsel     = WB_DMEM;
                ctrl_o.load_flag = 1'b1;
                rs1_addr_o       = rs1_idx_i;
            end
            OP_STORE: if (funct3 inside {FUNCT3_SB, FUNCT3_SH, FUNCT3_SW}) begin
                // Address is rs1 + S immediate, store data rides in rs2_value
                ctrl_o          = alu_ctrl(ALU_ADD, OPSEL2_IMM, imm_i.s, '0);
                ctrl_o.wbsel    = WB_NONE;
                ctrl_o.rf_w_en  = 1'b0;
                ctrl_o.mem_w_en = 1'b1;
                rs1_addr_o      = rs1_idx_i;
                rs2_addr_o      = rs2_idx_i;
            end
            default: ;
        endcase
    end

    always_comb begin
        assert final (!(ctrl_o.rf_w_en && ctrl_o.mem_w_en))
            else $error("ctrl_decode: register and memory write both enabled");
    end

endmodule

//--- rtl/branch_unit.sv
// Branch and jump resolution with next-PC select and redirect target
`timescale 1ns/1ps

module branch_unit import decode_pkg::*; (
    input  logic [XLEN-1:0] pc_i,
    input  br_kind_e        br_kind_i,
    input  imm_set_t        imm_i,
    input  logic [XLEN-1:0] rs1_value_i,
    input  logic [XLEN-1:0] rs2_value_i,
    output pcsel_e          pcsel_o,
    output logic [XLEN-1:0] branch_tar_o
);

    logic            eq;
    logic            lt;
    logic            ltu;
    logic            taken;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target;

    assign eq  = (rs1_value_i == rs2_value_i);
    assign lt  = ($signed(rs1_value_i) < $signed(rs2_value_i));
    assign ltu = (rs1_value_i < rs2_value_i);

    assign jalr_sum = rs1_value_i + imm_i.i;

    always_comb begin
        case (br_kind_i)
            BR_EQ:            taken = eq;
            BR_NE:            taken = !eq;
            BR_LT:            taken = lt;
            BR_GE:            taken = !lt;
            BR_LTU:           taken = ltu;
            BR_GEU:           taken = !ltu;
            BR_JAL, BR_JALR:  taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind_i)
            BR_JAL:  target = pc_i + imm_i.j;
            // Register-relative jump drops bit 0 of the sum
            BR_JALR: target = {jalr_sum[XLEN-1:1], 1'b0};
            default: target = pc_i + imm_i.b;
        endcase
    end

    assign pcsel_o      = taken ? PC_BRANCH : PC_PLUS4;
    assign branch_tar_o = taken ? target : '0;

    // Every redirect lands on a halfword boundary
    always_comb begin
        if (pcsel_o == PC_BRANCH) begin
            assert final (!branch_tar_o[0])
                else $error("branch_unit: odd redirect target %h", branch_tar_o);
        end
    end

endmodule

//--- rtl/id_ex_reg.sv
// Stallable ID/EX pipeline register that bubbles the load flag while held
`timescale 1ns/1ps

module id_ex_reg import decode_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_i,
    input  logic [XLEN-1:0] pc_i,
    input  ctrl_t           ctrl_i,
    input  logic [XLEN-1:0] rs1_value_i,
    input  logic [XLEN-1:0] rs2_value_i,
    output id_ex_t          id_ex_o
);

    id_ex_t held_view;

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex_o <= '0;
        end else if (stall_i) begin
            // Keep the bundle but drop the load so it is not counted twice
            id_ex_o.ctrl.load_flag <= 1'b0;
        end else begin
            id_ex_o.pc        <= pc_i;
            id_ex_o.ctrl      <= ctrl_i;
            id_ex_o.rs1_value <= rs1_value_i;
            id_ex_o.rs2_value <= rs2_value_i;
        end
    end

    // What a stalled edge should leave behind
    always_comb begin
        held_view                = id_ex_o;
        held_view.ctrl.load_flag = 1'b0;
    end

    property p_stall_holds;
        @(posedge clk) disable iff (reset)
        stall_i |=> (id_ex_o == $past(held_view));
    endproperty

    a_stall_holds: assert property (p_stall_holds)
        else $error("id_ex_reg: bundle changed across a stall");

endmodule

//--- rtl/decode_stage.sv
// Top level of the RV32I decode stage with same-cycle branch resolution
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       inst_i,
    input  logic [XLEN-1:0]       rs1_value_i,
    input  logic [XLEN-1:0]       rs2_value_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output pcsel_e                pcsel_o,
    output logic [XLEN-1:0]       branch_tar_o,
    output id_ex_t                id_ex_o
);

    imm_set_t              imm;
    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    logic [REG_ADDR_W-1:0] rd_idx;
    ctrl_t                 ctrl;
    br_kind_e              br_kind;

    imm_gen i_imm_gen (
        .inst_i    (inst_i),
        .imm_o     (imm),
        .rs1_idx_o (rs1_idx),
        .rs2_idx_o (rs2_idx),
        .rd_idx_o  (rd_idx)
    );

    ctrl_decode i_ctrl_decode (
        .inst_i     (inst_i),
        .imm_i      (imm),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rd_idx_i   (rd_idx),
        .ctrl_o     (ctrl),
        .br_kind_o  (br_kind),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o)
    );

    // Redirect is resolved here, not gated by the stall
    branch_unit i_branch_unit (
        .pc_i         (pc_i),
        .br_kind_i    (br_kind),
        .imm_i        (imm),
        .rs1_value_i  (rs1_value_i),
        .rs2_value_i  (rs2_value_i),
        .pcsel_o      (pcsel_o),
        .branch_tar_o (branch_tar_o)
    );

    id_ex_reg i_id_ex_reg (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall_i),
        .pc_i        (pc_i),
        .ctrl_i      (ctrl),
        .rs1_value_i (rs1_value_i),
        .rs2_value_i (rs2_value_i),
        .id_ex_o     (id_ex_o)
    );

endmodule

//--- tests/tb_decode_stage.sv
// Testbench for the RV32I decode stage, checked cycle by cycle against a reference decoder
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

    // Stimulus needs about 620 cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 2000;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        pcsel_e                pcsel;
        logic [XLEN-1:0]       tar;
    } expect_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  stall_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       inst_i;
    logic [XLEN-1:0]       rs1_value_i;
    logic [XLEN-1:0]       rs2_value_i;
    logic [REG_ADDR_W-1:0] rs1_addr_o;
    logic [REG_ADDR_W-1:0] rs2_addr_o;
    pcsel_e                pcsel_o;
    logic [XLEN-1:0]       branch_tar_o;
    id_ex_t                id_ex_o;

    integer          seed;
    int              cycles;
    int              check_count;
    int              err_count;
    int              test_checks;
    int              test_err;
    string           test_name;
    expect_t         now_exp;
    id_ex_t          exp_bundle;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    int              k;

    logic [2:0] br_f3 [6]   = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [2:0] load_f3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

    decode_stage i_dut (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .rs1_value_i  (rs1_value_i),
        .rs2_value_i  (rs2_value_i),
        .rs1_addr_o   (rs1_addr_o),
        .rs2_addr_o   (rs2_addr_o),
        .pcsel_o      (pcsel_o),
        .branch_tar_o (branch_tar_o),
        .id_ex_o      (id_ex_o)
    );

    always #10 clk = ~clk;

    function automatic logic [XLEN-1:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [XLEN-1:0] rand_pc();
        logic [XLEN-1:0] v;
        v = rnd();
        return {v[XLEN-1:2], 2'b00};
    endfunction

    // Control of any instruction that writes rd
    function automatic ctrl_t write_ctrl(alu_op_e op, opsel1_e s1, opsel2_e s2, wbsel_e wb,
                                         logic [XLEN-1:0] inst, logic [XLEN-1:0] imm);
        ctrl_t c;
        c         = '0;
        c.alu_op  = op;
        c.opsel1  = s1;
        c.opsel2  = s2;
        c.wbsel   = wb;
        c.rd_addr = inst[11:7];
        c.rf_w_en = 1'b1;
        c.imm     = imm;
        return c;
    endfunction

    // Expected decode of one instruction from the RV32I encoding rules
    function automatic expect_t predict(logic [XLEN-1:0] inst, logic [XLEN-1:0] pc,
                                        logic [XLEN-1:0] va, logic [XLEN-1:0] vb);
        expect_t         e;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic            alt;
        logic            shift;
        logic            taken;
        logic [XLEN-1:0] ii;
        logic [XLEN-1:0] ib;
        logic [XLEN-1:0] ij;
        alu_op_e         op;
        f3    = inst[14:12];
        f7    = inst[31:25];
        alt   = (f7 == 7'b0100000);
        shift = (f3 == 3'b001) || (f3 == 3'b101);
        ii    = {{20{inst[31]}}, inst[31:20]};
        ib    = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        ij    = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        e     = '0;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        case (inst[6:0])
            OP_OP: if (f7 == 7'd0 || (alt && (f3 == 3'b000 || f3 == 3'b101))) begin
                e.ctrl = write_ctrl(op, OPSEL1_RS1, OPSEL2_RS2, WB_ALU, inst, '0);
                e.rs1  = inst[19:15];
                e.rs2  = inst[24:20];
            end
            OP_OP_IMM: if (!shift || f7 == 7'd0 || (alt && f3 == 3'b101)) begin
                // No SUBI form, shifts take shamt zero-extended
                e.ctrl = write_ctrl((f3 == 3'b000) ? ALU_ADD : op, OPSEL1_RS1, OPSEL2_IMM,
                                    WB_ALU, inst, shift ? {27'd0, inst[24:20]} : ii);
                e.rs1  = inst[19:15];
            end
            OP_LUI: begin
                e.ctrl = write_ctrl(ALU_NOP, OPSEL1_NONE, OPSEL2_NONE, WB_IMM, inst,
                                    {inst[31:12], 12'd0});
            end
            OP_AUIPC: begin
                e.ctrl = write_ctrl(ALU_ADD, OPSEL1_PC, OPSEL2_IMM, WB_ALU, inst,
                                    {inst[31:12], 12'd0});
            end
            OP_JAL: begin
                e.ctrl  = write_ctrl(ALU_ADD, OPSEL1_PC, OPSEL2_FOUR, WB_ALU, inst, ij);
                e.pcsel = PC_BRANCH;
                e.tar   = pc + ij;
            end
            OP_JALR: if (f3 == 3'b000) begin
                e.ctrl  = write_ctrl(ALU_ADD, OPSEL1_PC, OPSEL2_FOUR, WB_ALU, inst, ii);
                e.rs1   = inst[19:15];
                e.pcsel = PC_BRANCH;
                e.tar   = (va + ii) & ~32'd1;
            end
            OP_BRANCH: if (f3 != 3'b010 && f3 != 3'b011) begin
                case (f3)
                    3'b000:  taken = (va == vb);
                    3'b001:  taken = (va != vb);
                    3'b100:  taken = ($signed(va) < $signed(vb));
                    3'b101:  taken = ($signed(va) >= $signed(vb));
                    3'b110:  taken = (va < vb);
                    default: taken = (va >= vb);
                endcase
                e.ctrl.imm = ib;
                e.rs1      = inst[19:15];
                e.rs2      = inst[24:20];
                if (taken) begin
                    e.pcsel = PC_BRANCH;
                    e.tar   = pc + ib;
                end
            end
            OP_LOAD: if (f3 != 3'b011 && f3 != 3'b110 && f3 != 3'b111) begin
                e.ctrl           = write_ctrl(ALU_ADD, OPSEL1_RS1, OPSEL2_IMM, WB_DMEM, inst, ii);
                e.ctrl.load_flag = 1'b1;
                e.rs1            = inst[19:15];
            end
            OP_STORE: if (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b010) begin
                e.ctrl          = write_ctrl(ALU_ADD, OPSEL1_RS1, OPSEL2_IMM, WB_NONE, inst,
                                             {{20{inst[31]}}, inst[31:25], inst[11:7]});
                e.ctrl.rd_addr  = '0;
                e.ctrl.rf_w_en  = 1'b0;
                e.ctrl.mem_w_en = 1'b1;
                e.rs1           = inst[19:15];
                e.rs2           = inst[24:20];
            end
            default: ;
        endcase
        return e;
    endfunction

    // Random OP, OP-IMM, LUI and AUIPC words, with a few fully random ones
    function automatic logic [XLEN-1:0] gen_alu();
        logic [XLEN-1:0] v;
        logic [XLEN-1:0] sel;
        logic [6:0]      f7;
        v   = rnd();
        sel = rnd();
        case (sel[5:4])
            2'd1:    f7 = 7'b0100000;
            2'd3:    f7 = v[31:25];
            default: f7 = 7'd0;
        endcase
        case (sel[2:0])
            3'd0, 3'd1, 3'd2: return {f7, v[24:7], OP_OP};
            3'd3, 3'd4: begin
                if (v[13:12] == 2'b01)
                    return {f7, v[24:7], OP_OP_IMM};
                return {v[31:7], OP_OP_IMM};
            end
            3'd5:    return {v[31:7], OP_LUI};
            3'd6:    return {v[31:7], OP_AUIPC};
            default: return v;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] gen_load();
        logic [XLEN-1:0] v;
        v = rnd();
        return {v[31:15], load_f3[rnd() % 5], v[11:7], OP_LOAD};
    endfunction

    function automatic logic [XLEN-1:0] gen_store();
        logic [XLEN-1:0] v;
        v = rnd();
        return {v[31:15], load_f3[rnd() % 3], v[11:7], OP_STORE};
    endfunction

    function automatic logic [XLEN-1:0] gen_mix();
        case (rnd() % 3)
            0:       return gen_load();
            1:       return gen_store();
            default: return gen_alu();
        endcase
    endfunction

    task automatic apply(logic [XLEN-1:0] inst, logic [XLEN-1:0] pc,
                         logic [XLEN-1:0] va, logic [XLEN-1:0] vb, logic stall);
        @(posedge clk);
        inst_i      <= inst;
        pc_i        <= pc;
        rs1_value_i <= va;
        rs2_value_i <= vb;
        stall_i     <= stall;
    endtask

    task automatic compare_value(string what, logic [159:0] expv, logic [159:0] gotv);
        check_count++;
        test_checks++;
        assert (gotv === expv) else begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expv, gotv);
            err_count++;
            test_err++;
        end
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_checks = 0;
        test_err    = 0;
    endtask

    task automatic report_test();
        $display("%s: %0d checks, %0d errors", test_name, test_checks, test_err);
    endtask

    // Two more edges let the last instruction reach id_ex_o and be checked
    task automatic end_test();
        repeat (2) @(posedge clk);
        report_test();
    endtask

    // Outputs are compared mid-cycle, where inputs and the register are settled
    always @(negedge clk) begin
        now_exp = predict(inst_i, pc_i, rs1_value_i, rs2_value_i);
        compare_value("rs1_addr", now_exp.rs1, rs1_addr_o);
        compare_value("rs2_addr", now_exp.rs2, rs2_addr_o);
        compare_value("pcsel", now_exp.pcsel, pcsel_o);
        compare_value("branch_tar", now_exp.tar, branch_tar_o);
        compare_value("id_ex", exp_bundle, id_ex_o);
        if (reset) begin
            exp_bundle = '0;
        end else if (stall_i) begin
            exp_bundle.ctrl.load_flag = 1'b0;
        end else begin
            exp_bundle.pc        = pc_i;
            exp_bundle.ctrl      = now_exp.ctrl;
            exp_bundle.rs1_value = rs1_value_i;
            exp_bundle.rs2_value = rs2_value_i;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        seed        = 32'h7dda307e;
        reset       = 1'b1;
        stall_i     = 1'b0;
        pc_i        = '0;
        inst_i      = '0;
        rs1_value_i = '0;
        rs2_value_i = '0;
        cycles      = 0;
        check_count = 0;
        err_count   = 0;
        exp_bundle  = '0;
        start_test("reset");
        repeat (8) @(posedge clk);
        report_test();

        // A stalled load right after reset must leave the bundle empty
        start_test("reset_hold");
        reset   <= 1'b0;
        stall_i <= 1'b1;
        inst_i  <= {12'h010, 5'd3, 3'b010, 5'd7, OP_LOAD};
        repeat (3) begin
            @(negedge clk);
            compare_value("id_ex zero", '0, id_ex_o);
        end
        end_test();

        start_test("alu");
        repeat (200) apply(gen_alu(), rand_pc(), rnd(), rnd(), 1'b0);
        end_test();

        start_test("branch");
        repeat (150) begin
            a = rnd();
            case (rnd() % 4)
                0:       b = a;
                1:       b = a + 1;
                2:       b = a ^ 32'h8000_0000;
                default: b = rnd();
            endcase
            r = rnd();
            apply({r[31:15], br_f3[rnd() % 6], r[11:7], OP_BRANCH}, rand_pc(), a, b, 1'b0);
        end
        end_test();

        start_test("jump");
        repeat (20) begin
            r = rnd();
            apply({r[31:7], OP_JAL}, rand_pc(), rnd(), rnd(), 1'b0);
            r = rnd();
            apply({r[31:15], 3'b000, r[11:7], OP_JALR}, rand_pc(), rnd(), rnd(), 1'b0);
        end
        end_test();

        start_test("load_store");
        repeat (20) begin
            apply(gen_load(), rand_pc(), rnd(), rnd(), 1'b0);
            apply(gen_store(), rand_pc(), rnd(), rnd(), 1'b0);
        end
        end_test();

        // Inputs keep changing under the stall, only the unstalled edge captures
        start_test("stall");
        repeat (60) begin
            apply(gen_mix(), rand_pc(), rnd(), rnd(), 1'b0);
            k = rnd() % 4;
            repeat (k) apply(gen_mix(), rand_pc(), rnd(), rnd(), 1'b1);
        end
        end_test();

        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verilog.f
rtl/decode_pkg.sv
rtl/imm_gen.sv
rtl/ctrl_decode.sv
rtl/branch_unit.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
tests/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - rtl/decode_pkg.sv
  - rtl/imm_gen.sv
  - rtl/ctrl_decode.sv
  - rtl/branch_unit.sv
  - rtl/id_ex_reg.sv
  - rtl/decode_stage.sv
  - target: test
    files:
      - tests/tb_decode_stage.sv
